// File: axi_id_serialize.f
+incdir+hw
hw/axi_id_serialize_pkg.sv
hw/axi_id_demux.sv
hw/axi_serializer.sv
hw/axi_id_mux.sv
hw/axi_id_serialize.sv
dv/tb_axi_mem_model.sv
dv/tb_axi_id_serialize.sv

// File: dv/tb_axi_id_serialize.sv
// Testbench for the AXI ID serializer: random reads, scoreboard assertions and a memory model
`include "axi_id_serialize_config.svh"

module tb_axi_id_serialize;

  timeunit 1ns;
  timeprecision 1ps;

  import axi_id_serialize_pkg::*;

  logic         clk;
  logic         rst_n;
  slv_ar_chan_t slv_ar;
  logic         slv_ar_valid;
  logic         slv_ar_ready;
  slv_r_chan_t  slv_r;
  logic         slv_r_valid;
  logic         slv_r_ready;
  mst_ar_chan_t mst_ar;
  logic         mst_ar_valid;
  logic         mst_ar_ready;
  mst_r_chan_t  mst_r;
  logic         mst_r_valid;
  logic         mst_r_ready;
  logic         ar_stall;
  logic         hold;
  logic         bp_mode;
  logic         sent_any;
  logic [17:0]  seq;
  logic [31:0]  lfsr_q = 32'h1573449c;
  string        cur_name = "reset_idle";
  int beats_planned, beats_seen, mst_beats, cycle_cnt, peak_cnt;
  int test_err, total_err, tests_failed;

  // Scoreboard, one circular list of bursts per slave ID
  logic [31:0] sb_addr [64][16];
  logic [7:0]  sb_len [64][16];
  logic [3:0]  wr_ptr [64];
  logic [3:0]  mst_ptr [64];
  logic [3:0]  rd_ptr [64];
  logic [7:0]  beat_cnt [64];
  int          infl_cnt [4];
  logic [5:0]  infl_sid [4];

  logic        ar_hs, mr_last_hs, sr_hs, r_pending, exp_last;
  logic [5:0]  ar_tid, r_sid;
  logic [1:0]  mid;
  logic [39:0] exp_ar;
  logic [31:0] exp_data;

  axi_id_serialize dut (
    .clk_i(clk), .rst_n_i(rst_n),
    .slv_ar_i(slv_ar), .slv_ar_valid_i(slv_ar_valid), .slv_ar_ready_o(slv_ar_ready),
    .slv_r_o(slv_r), .slv_r_valid_o(slv_r_valid), .slv_r_ready_i(slv_r_ready),
    .mst_ar_o(mst_ar), .mst_ar_valid_o(mst_ar_valid), .mst_ar_ready_i(mst_ar_ready),
    .mst_r_i(mst_r), .mst_r_valid_i(mst_r_valid), .mst_r_ready_o(mst_r_ready)
  );

  tb_axi_mem_model i_mem (
    .clk_i(clk), .rst_n_i(rst_n),
    .ar_i(mst_ar), .ar_valid_i(mst_ar_valid), .ar_ready_o(mst_ar_ready),
    .r_o(mst_r), .r_valid_o(mst_r_valid), .r_ready_i(mst_r_ready),
    .ar_stall_i(ar_stall), .hold_i(hold)
  );

  always #4 clk = ~clk;

  function automatic logic lfsr_bit();
    lfsr_bit = lfsr_q[31];
    lfsr_q   = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  task automatic log_mismatch(input string check, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error %s/%s: expected 'h%0h, actual 'h%0h", cur_name, check, exp, act);
    test_err++;
  endtask

  task automatic raise_failure(input string what);
    $display("Failure in %s: %s", cur_name, what);
    test_err++;
  endtask

  // Address carries the slave ID in 13:8 and a sequence number above it
  task automatic send_read(input logic [5:0] id, input logic [7:0] len);
    slv_ar.id     = id;
    slv_ar.addr   = {seq, id, 8'h00};
    slv_ar.len    = len;
    slv_ar_valid  = 1'b1;
    sent_any      = 1'b1;
    seq++;
    beats_planned += int'(len) + 1;
    do @(posedge clk); while (!slv_ar_ready);
    #1 slv_ar_valid = 1'b0;
  endtask

  // Kind 0 draws any ID, 1 draws from 1, 5 and 9, 2 draws from IDs 0 to 7
  task automatic run_random(input int n, input int kind);
    logic [5:0] id;
    logic [7:0] len;
    for (int i = 0; i < n; i++) begin
      case (kind)
        1:       id = 6'(1 + 4 * (take_bits(2) % 3));
        2:       id = 6'(take_bits(3));
        default: id = 6'(take_bits(6));
      endcase
      len = 8'(take_bits(2));
      send_read(id, len);
    end
  endtask

  task automatic wait_drain();
    while (beats_seen != beats_planned) @(posedge clk);
    #1;
  endtask

  task automatic end_test();
    if (test_err == 0) $display("test %s: ok", cur_name);
    else $display("test %s: %0d errors", cur_name, test_err);
    if (test_err != 0) tests_failed++;
    total_err += test_err;
    test_err   = 0;
  endtask

  assign ar_hs      = mst_ar_valid && mst_ar_ready;
  assign mr_last_hs = mst_r_valid && mst_r_ready && mst_r.last;
  assign sr_hs      = slv_r_valid && slv_r_ready;
  assign ar_tid     = mst_ar.addr[13:8];
  assign mid        = mst_ar.id;
  assign r_sid      = slv_r.id;
  assign exp_ar     = {sb_addr[ar_tid][mst_ptr[ar_tid]], sb_len[ar_tid][mst_ptr[ar_tid]]};
  assign exp_data   = sb_addr[r_sid][rd_ptr[r_sid]] + {22'd0, beat_cnt[r_sid], 2'b00};
  assign exp_last   = (beat_cnt[r_sid] == sb_len[r_sid][rd_ptr[r_sid]]);
  assign r_pending  = (rd_ptr[r_sid] != wr_ptr[r_sid]);

  always @(posedge clk) begin
    if (slv_ar_valid && slv_ar_ready) begin
      sb_addr[slv_ar.id][wr_ptr[slv_ar.id]] <= slv_ar.addr;
      sb_len[slv_ar.id][wr_ptr[slv_ar.id]]  <= slv_ar.len;
      wr_ptr[slv_ar.id] <= wr_ptr[slv_ar.id] + 4'd1;
    end
    if (ar_hs) begin
      mst_ptr[ar_tid] <= mst_ptr[ar_tid] + 4'd1;
      infl_sid[mid]   <= ar_tid;
    end
    // Master-side reads in flight, from request to last beat
    for (int m = 0; m < 4; m++) begin
      infl_cnt[m] <= infl_cnt[m] + int'(ar_hs && mid == m) - int'(mr_last_hs && mst_r.id == m);
    end
    if (infl_cnt[1] > peak_cnt) peak_cnt <= infl_cnt[1];
    if (mst_r_valid && mst_r_ready) mst_beats <= mst_beats + 1;
    if (sr_hs) begin
      beats_seen <= beats_seen + 1;
      if (r_pending && slv_r.last) begin
        rd_ptr[r_sid]   <= rd_ptr[r_sid] + 4'd1;
        beat_cnt[r_sid] <= '0;
      end else if (r_pending) begin
        beat_cnt[r_sid] <= beat_cnt[r_sid] + 8'd1;
      end
    end
  end

  a_reset_idle : assert property (@(posedge clk) disable iff (!rst_n)
    !sent_any |-> !mst_ar_valid && !slv_r_valid)
    else raise_failure("a valid rose after reset before any request was sent");
  a_id_map : assert property (@(posedge clk) disable iff (!rst_n)
    mst_ar_valid |-> mst_ar.id == ar_tid[1:0])
    else log_mismatch("id_map", $sampled(ar_tid[1:0]), $sampled(mst_ar.id));
  a_addr_pass : assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> {mst_ar.addr, mst_ar.len} == exp_ar)
    else log_mismatch("addr_pass", $sampled(exp_ar), $sampled({mst_ar.addr, mst_ar.len}));
  a_serialize : assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs && infl_cnt[mid] != 0 |-> ar_tid == infl_sid[mid])
    else log_mismatch("serialize", $sampled(infl_sid[mid]), $sampled(ar_tid));
  a_slot_limit : assert property (@(posedge clk) disable iff (!rst_n)
    infl_cnt[0] <= `AXI_MAX_TXNS_PER_ID && infl_cnt[1] <= `AXI_MAX_TXNS_PER_ID &&
    infl_cnt[2] <= `AXI_MAX_TXNS_PER_ID && infl_cnt[3] <= `AXI_MAX_TXNS_PER_ID)
    else raise_failure("a master ID has more reads in flight than the limit");
  a_r_known : assert property (@(posedge clk) disable iff (!rst_n) sr_hs |-> r_pending)
    else raise_failure("slave port returned a beat with no outstanding burst");
  a_r_id : assert property (@(posedge clk) disable iff (!rst_n)
    slv_r_valid |-> slv_r.data[13:8] == slv_r.id)
    else log_mismatch("resp_id", $sampled(slv_r.data[13:8]), $sampled(slv_r.id));
  a_r_data : assert property (@(posedge clk) disable iff (!rst_n)
    sr_hs && r_pending |-> slv_r.data == exp_data)
    else log_mismatch("resp_data", $sampled(exp_data), $sampled(slv_r.data));
  a_r_last : assert property (@(posedge clk) disable iff (!rst_n)
    sr_hs && r_pending |-> {slv_r.resp, slv_r.last} == {2'b00, exp_last})
    else log_mismatch("resp_last", $sampled({2'b00, exp_last}),
                      $sampled({slv_r.resp, slv_r.last}));

  // Random draws happen at the edge so they never interleave with the stimulus draws
  always @(posedge clk) begin
    logic rdy_draw;
    logic stall_draw;
    rdy_draw   = lfsr_bit();
    stall_draw = (take_bits(2) == 32'd3);
    #1;
    slv_r_ready = bp_mode ? rdy_draw : 1'b1;
    ar_stall    = stall_draw;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > 40 * beats_planned + 200) begin
      $display("Timeout after %0d cycles, %0d of %0d beats returned",
               cycle_cnt, beats_seen, beats_planned);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    slv_ar = '0;
    slv_ar_valid = 1'b0;
    slv_r_ready = 1'b0;
    ar_stall = 1'b0;
    hold = 1'b0;
    bp_mode = 1'b0;
    sent_any = 1'b0;
    seq = '0;
    for (int i = 0; i < 64; i++) begin
      wr_ptr[i] = '0;
      mst_ptr[i] = '0;
      rd_ptr[i] = '0;
      beat_cnt[i] = '0;
    end
    for (int m = 0; m < 4; m++) infl_cnt[m] = 0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (5) @(posedge clk);
    #1 end_test();

    cur_name = "id_map";
    run_random(16, 0);
    wait_drain();
    end_test();

    cur_name = "serialize";
    run_random(20, 1);
    wait_drain();
    end_test();

    // Slot 1 fills while the memory holds its responses, slots 2 and 3 still pass
    cur_name = "slot_limit";
    peak_cnt = 0;
    hold = 1'b1;
    fork
      begin
        for (int i = 0; i < 4; i++) send_read(6'd1, 8'(take_bits(2)));
        send_read(6'd2, 8'(take_bits(2)));
        send_read(6'd3, 8'(take_bits(2)));
        assert (hold) else raise_failure("reads on other slots waited for the full slot");
        // Fifth read of ID 1 waits until a read of slot 1 completes
        send_read(6'd1, 8'(take_bits(2)));
        send_read(6'd5, 8'(take_bits(2)));
      end
      begin
        repeat (60) @(posedge clk);
        #1 hold = 1'b0;
      end
    join
    wait_drain();
    assert (peak_cnt == `AXI_MAX_TXNS_PER_ID)
      else log_mismatch("peak_in_flight", `AXI_MAX_TXNS_PER_ID, peak_cnt);
    end_test();

    cur_name = "resp_data";
    run_random(24, 2);
    wait_drain();
    end_test();

    cur_name = "backpressure";
    bp_mode = 1'b1;
    run_random(24, 0);
    wait_drain();
    bp_mode = 1'b0;
    assert (mst_beats == beats_seen)
      else log_mismatch("beat_count", mst_beats, beats_seen);
    for (int i = 0; i < 64; i++) begin
      assert (rd_ptr[i] == wr_ptr[i]) else raise_failure("a burst never completed");
    end
    end_test();

    $display("6 tests run, %0d failed, %0d errors", tests_failed, total_err);
    if (total_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: dv/tb_axi_mem_model.sv
// AXI read responder for the testbench: in-order bursts with data derived from the address
`include "axi_id_serialize_config.svh"

module tb_axi_mem_model (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  axi_id_serialize_pkg::mst_ar_chan_t ar_i,
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  output axi_id_serialize_pkg::mst_r_chan_t  r_o,
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  input  logic                               ar_stall_i,
  input  logic                               hold_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import axi_id_serialize_pkg::*;

  mst_ar_chan_t pend[$];
  int unsigned  beat;
  logic         in_reset;
  logic         stall;
  logic         hold;
  logic         r_hs;

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    beat       = 0;
  end

  always @(posedge clk_i) begin
    // Everything is sampled at the edge, outputs change 1 ns later
    in_reset = !rst_n_i;
    stall    = ar_stall_i;
    hold     = hold_i;
    r_hs     = r_valid_o && r_ready_i;
    if (in_reset) begin
      pend.delete();
      beat = 0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        pend.push_back(ar_i);
      end
      if (r_hs && r_o.last) begin
        void'(pend.pop_front());
        beat = 0;
      end else if (r_hs) begin
        beat++;
      end
    end
    #1;
    ar_ready_o = !in_reset && !stall;
    if (in_reset) begin
      r_valid_o = 1'b0;
    end else if (r_hs || !r_valid_o) begin
      // A presented beat stays until it transfers, hold only delays the next one
      if (pend.size() > 0 && !hold) begin
        r_valid_o = 1'b1;
        r_o.id    = pend[0].id;
        r_o.data  = pend[0].addr + 32'(beat) * 32'd4;
        r_o.resp  = 2'b00;
        r_o.last  = (beat == int'(pend[0].len));
      end else begin
        r_valid_o = 1'b0;
      end
    end
  end

endmodule

// File: hw/axi_id_serialize.sv
// AXI ID serializer: folds wide read IDs onto four master IDs, serializing colliding IDs
`include "axi_id_serialize_config.svh"

module axi_id_serialize (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  axi_id_serialize_pkg::slv_ar_chan_t slv_ar_i,
  input  logic                               slv_ar_valid_i,
  output logic                               slv_ar_ready_o,
  output axi_id_serialize_pkg::slv_r_chan_t  slv_r_o,
  output logic                               slv_r_valid_o,
  input  logic                               slv_r_ready_i,
  output axi_id_serialize_pkg::mst_ar_chan_t mst_ar_o,
  output logic                               mst_ar_valid_o,
  input  logic                               mst_ar_ready_i,
  input  axi_id_serialize_pkg::mst_r_chan_t  mst_r_i,
  input  logic                               mst_r_valid_i,
  output logic                               mst_r_ready_o
);

  import axi_id_serialize_pkg::*;

  // Demux to serializers, original slave IDs
  slv_ar_chan_t [`AXI_NUM_SLOTS-1:0] dmx_ar;
  logic         [`AXI_NUM_SLOTS-1:0] dmx_ar_valid;
  logic         [`AXI_NUM_SLOTS-1:0] dmx_ar_ready;
  slv_r_chan_t  [`AXI_NUM_SLOTS-1:0] dmx_r;
  logic         [`AXI_NUM_SLOTS-1:0] dmx_r_valid;
  logic         [`AXI_NUM_SLOTS-1:0] dmx_r_ready;

  // Serializers to mux, request IDs forced to zero
  slv_ar_chan_t [`AXI_NUM_SLOTS-1:0] ser_ar;
  logic         [`AXI_NUM_SLOTS-1:0] ser_ar_valid;
  logic         [`AXI_NUM_SLOTS-1:0] ser_ar_ready;
  slv_r_chan_t  [`AXI_NUM_SLOTS-1:0] ser_r;
  logic         [`AXI_NUM_SLOTS-1:0] ser_r_valid;
  logic         [`AXI_NUM_SLOTS-1:0] ser_r_ready;

  axi_id_demux i_axi_id_demux (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_ar_i        (slv_ar_i),
    .slv_ar_valid_i  (slv_ar_valid_i),
    .slv_ar_ready_o  (slv_ar_ready_o),
    .slv_r_o         (slv_r_o),
    .slv_r_valid_o   (slv_r_valid_o),
    .slv_r_ready_i   (slv_r_ready_i),
    .slot_ar_o       (dmx_ar),
    .slot_ar_valid_o (dmx_ar_valid),
    .slot_ar_ready_i (dmx_ar_ready),
    .slot_r_i        (dmx_r),
    .slot_r_valid_i  (dmx_r_valid),
    .slot_r_ready_o  (dmx_r_ready)
  );

  for (genvar i = 0; i < `AXI_NUM_SLOTS; i++) begin : gen_serializers
    axi_serializer i_axi_serializer (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .slv_ar_i       (dmx_ar[i]),
      .slv_ar_valid_i (dmx_ar_valid[i]),
      .slv_ar_ready_o (dmx_ar_ready[i]),
      .slv_r_o        (dmx_r[i]),
      .slv_r_valid_o  (dmx_r_valid[i]),
      .slv_r_ready_i  (dmx_r_ready[i]),
      .mst_ar_o       (ser_ar[i]),
      .mst_ar_valid_o (ser_ar_valid[i]),
      .mst_ar_ready_i (ser_ar_ready[i]),
      .mst_r_i        (ser_r[i]),
      .mst_r_valid_i  (ser_r_valid[i]),
      .mst_r_ready_o  (ser_r_ready[i])
    );
  end

  axi_id_mux i_axi_id_mux (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slot_ar_i       (ser_ar),
    .slot_ar_valid_i (ser_ar_valid),
    .slot_ar_ready_o (ser_ar_ready),
    .slot_r_o        (ser_r),
    .slot_r_valid_o  (ser_r_valid),
    .slot_r_ready_i  (ser_r_ready),
    .mst_ar_o        (mst_ar_o),
    .mst_ar_valid_o  (mst_ar_valid_o),
    .mst_ar_ready_i  (mst_ar_ready_i),
    .mst_r_i         (mst_r_i),
    .mst_r_valid_i   (mst_r_valid_i),
    .mst_r_ready_o   (mst_r_ready_o)
  );

endmodule

// File: hw/axi_id_mux.sv
// AXI ID mux: arbitrates slot reads onto the master port with the slot index as ID
`include "axi_id_serialize_config.svh"

module axi_id_mux (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  axi_id_serialize_pkg::slv_ar_chan_t [`AXI_NUM_SLOTS-1:0] slot_ar_i,
  input  logic [`AXI_NUM_SLOTS-1:0]                               slot_ar_valid_i,
  output logic [`AXI_NUM_SLOTS-1:0]                               slot_ar_ready_o,
  output axi_id_serialize_pkg::slv_r_chan_t [`AXI_NUM_SLOTS-1:0]  slot_r_o,
  output logic [`AXI_NUM_SLOTS-1:0]                               slot_r_valid_o,
  input  logic [`AXI_NUM_SLOTS-1:0]                               slot_r_ready_i,
  output axi_id_serialize_pkg::mst_ar_chan_t                      mst_ar_o,
  output logic                                                    mst_ar_valid_o,
  input  logic                                                    mst_ar_ready_i,
  input  axi_id_serialize_pkg::mst_r_chan_t                       mst_r_i,
  input  logic                                                    mst_r_valid_i,
  output logic                                                    mst_r_ready_o
);

  import axi_id_serialize_pkg::*;

  mst_ar_chan_t ar_d;
  mst_ar_chan_t ar_q;
  logic         ar_valid_q;
  logic         ar_any;
  logic         reg_free;
  slot_sel_t    ar_gnt;
  slot_sel_t    rr_ptr_q;
  slot_sel_t    r_sel;

  assign ar_any = |slot_ar_valid_i;
  assign ar_gnt = rr_pick(slot_ar_valid_i, rr_ptr_q);

  // Register can load when empty or when it drains this cycle
  assign reg_free = !ar_valid_q || mst_ar_ready_i;

  always_comb begin
    for (int i = 0; i < `AXI_NUM_SLOTS; i++) begin
      slot_ar_ready_o[i] = reg_free && ar_any && (ar_gnt == slot_sel_t'(i));
    end
  end

  // Slot index replaces the zeroed serializer ID
  always_comb begin
    ar_d.id   = mst_id_t'(ar_gnt);
    ar_d.addr = slot_ar_i[ar_gnt].addr;
    ar_d.len  = slot_ar_i[ar_gnt].len;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ar_valid_q <= 1'b0;
      rr_ptr_q   <= '0;
    end else if (reg_free) begin
      ar_valid_q <= ar_any;
      if (ar_any) begin
        rr_ptr_q <= slot_sel_t'((int'(ar_gnt) + 1) % `AXI_NUM_SLOTS);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_free && ar_any) begin
      ar_q <= ar_d;
    end
  end

  assign mst_ar_o       = ar_q;
  assign mst_ar_valid_o = ar_valid_q;

  // Response ID names the slot directly
  assign r_sel = slot_sel_t'(mst_r_i.id);

  always_comb begin
    for (int i = 0; i < `AXI_NUM_SLOTS; i++) begin
      slot_r_o[i].id    = '0;
      slot_r_o[i].data  = mst_r_i.data;
      slot_r_o[i].resp  = mst_r_i.resp;
      slot_r_o[i].last  = mst_r_i.last;
      slot_r_valid_o[i] = mst_r_valid_i && (r_sel == slot_sel_t'(i));
    end
  end

  assign mst_r_ready_o = slot_r_ready_i[r_sel];

  a_ar_valid_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o);

  a_ar_payload_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> $stable(mst_ar_o));

endmodule

// File: hw/axi_serializer.sv
// AXI read serializer: admits reads of one slave ID at a time and restores response IDs
`include "axi_id_serialize_config.svh"

module axi_serializer (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  axi_id_serialize_pkg::slv_ar_chan_t slv_ar_i,
  input  logic                               slv_ar_valid_i,
  output logic                               slv_ar_ready_o,
  output axi_id_serialize_pkg::slv_r_chan_t  slv_r_o,
  output logic                               slv_r_valid_o,
  input  logic                               slv_r_ready_i,
  output axi_id_serialize_pkg::slv_ar_chan_t mst_ar_o,
  output logic                               mst_ar_valid_o,
  input  logic                               mst_ar_ready_i,
  input  axi_id_serialize_pkg::slv_r_chan_t  mst_r_i,
  input  logic                               mst_r_valid_i,
  output logic                               mst_r_ready_o
);

  import axi_id_serialize_pkg::*;

  typedef logic [$clog2(`AXI_MAX_TXNS_PER_ID + 1)-1:0] cnt_t;

  cnt_t    cnt_q;
  slv_id_t id_q;
  logic    admit;
  logic    ar_hs;
  logic    r_done;

  // Free slot takes any ID, a busy one only more reads of its own ID
  assign admit = (cnt_q == '0) ||
                 ((slv_ar_i.id == id_q) && (cnt_q < cnt_t'(`AXI_MAX_TXNS_PER_ID)));

  always_comb begin
    mst_ar_o    = slv_ar_i;
    mst_ar_o.id = '0;
  end

  assign mst_ar_valid_o = slv_ar_valid_i && admit;
  assign slv_ar_ready_o = mst_ar_ready_i && admit;

  // Responses go back under the ID held for this slot
  always_comb begin
    slv_r_o    = mst_r_i;
    slv_r_o.id = id_q;
  end

  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;

  assign ar_hs  = slv_ar_valid_i && slv_ar_ready_o;
  assign r_done = mst_r_valid_i && mst_r_ready_o && mst_r_i.last;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({ar_hs, r_done})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q <= slv_ar_i.id;
    end
  end

  a_cnt_limit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= cnt_t'(`AXI_MAX_TXNS_PER_ID));

  // Mux routing must never hand this slot a burst it did not issue
  a_no_stray_resp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_r_valid_i |-> cnt_q != '0);

endmodule

// File: hw/axi_id_demux.sv
// AXI ID demux: steers read requests to ID slots and returns slot bursts to the slave port
`include "axi_id_serialize_config.svh"

module axi_id_demux (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  axi_id_serialize_pkg::slv_ar_chan_t                      slv_ar_i,
  input  logic                                                    slv_ar_valid_i,
  output logic                                                    slv_ar_ready_o,
  output axi_id_serialize_pkg::slv_r_chan_t                       slv_r_o,
  output logic                                                    slv_r_valid_o,
  input  logic                                                    slv_r_ready_i,
  output axi_id_serialize_pkg::slv_ar_chan_t [`AXI_NUM_SLOTS-1:0] slot_ar_o,
  output logic [`AXI_NUM_SLOTS-1:0]                               slot_ar_valid_o,
  input  logic [`AXI_NUM_SLOTS-1:0]                               slot_ar_ready_i,
  input  axi_id_serialize_pkg::slv_r_chan_t [`AXI_NUM_SLOTS-1:0]  slot_r_i,
  input  logic [`AXI_NUM_SLOTS-1:0]                               slot_r_valid_i,
  output logic [`AXI_NUM_SLOTS-1:0]                               slot_r_ready_o
);

  import axi_id_serialize_pkg::*;

  slot_sel_t ar_sel;
  slot_sel_t r_gnt;
  slot_sel_t r_sel_q;
  slot_sel_t rr_ptr_q;
  logic      r_lock_q;
  logic      r_last_hs;

  // Request slot is the ID folded modulo the slot count
  assign ar_sel = slot_sel_t'(slv_ar_i.id % `AXI_NUM_SLOTS);

  always_comb begin
    for (int i = 0; i < `AXI_NUM_SLOTS; i++) begin
      slot_ar_o[i]       = slv_ar_i;
      slot_ar_valid_o[i] = slv_ar_valid_i && (ar_sel == slot_sel_t'(i));
    end
  end

  assign slv_ar_ready_o = slot_ar_ready_i[ar_sel];

  // A presented or running burst keeps its slot until the last beat
  assign r_gnt = r_lock_q ? r_sel_q : rr_pick(slot_r_valid_i, rr_ptr_q);

  assign slv_r_o       = slot_r_i[r_gnt];
  assign slv_r_valid_o = slot_r_valid_i[r_gnt];

  always_comb begin
    for (int i = 0; i < `AXI_NUM_SLOTS; i++) begin
      slot_r_ready_o[i] = slv_r_ready_i && (r_gnt == slot_sel_t'(i));
    end
  end

  assign r_last_hs = slv_r_valid_o && slv_r_ready_i && slv_r_o.last;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_lock_q <= 1'b0;
      r_sel_q  <= '0;
      rr_ptr_q <= '0;
    end else if (r_last_hs) begin
      r_lock_q <= 1'b0;
      rr_ptr_q <= slot_sel_t'((int'(r_gnt) + 1) % `AXI_NUM_SLOTS);
    end else if (slv_r_valid_o) begin
      r_lock_q <= 1'b1;
      r_sel_q  <= r_gnt;
    end
  end

  // Holds only if every slot keeps its response valid while stalled
  a_r_valid_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o);

endmodule

// File: hw/axi_id_serialize_pkg.sv
// AXI ID serializer types: read channel structs for both ports and the slot index
`include "axi_id_serialize_config.svh"

package axi_id_serialize_pkg;

  typedef logic [`AXI_SLV_ID_WIDTH-1:0] slv_id_t;
  typedef logic [`AXI_MST_ID_WIDTH-1:0] mst_id_t;
  typedef logic [`AXI_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0]   data_t;
  typedef logic [`AXI_LEN_WIDTH-1:0]    len_t;
  typedef logic [1:0]                   resp_t;

  // Slot index, doubles as the master port ID
  typedef logic [$clog2(`AXI_NUM_SLOTS)-1:0] slot_sel_t;

  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ar_chan_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } slv_r_chan_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ar_chan_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } mst_r_chan_t;

  // First requesting slot at or after ptr, wrapping around
  function automatic slot_sel_t rr_pick(input logic [`AXI_NUM_SLOTS-1:0] req,
                                        input slot_sel_t                 ptr);
    slot_sel_t idx;
    rr_pick = ptr;
    // Walk backwards so the nearest requester is the last one written
    for (int i = `AXI_NUM_SLOTS - 1; i >= 0; i--) begin
      idx = slot_sel_t'((int'(ptr) + i) % `AXI_NUM_SLOTS);
      if (req[idx]) begin
        rr_pick = idx;
      end
    end
  endfunction

endpackage

// File: hw/axi_id_serialize_config.svh
// AXI ID serializer configuration: port widths, slot count and per-slot read limit
`ifndef AXI_ID_SERIALIZE_CONFIG_SVH
`define AXI_ID_SERIALIZE_CONFIG_SVH

`define AXI_SLV_ID_WIDTH 6
`define AXI_MST_ID_WIDTH 2
`define AXI_NUM_SLOTS 4
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_LEN_WIDTH 8
`define AXI_MAX_TXNS_PER_ID 4

`endif
